// ==== logic/bus_slave_pkg.sv ====
`default_nettype none

package bus_slave_pkg;

  // bus word types
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [1:0]  axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // sram window starts here, size set by MEM_WORDS
  localparam addr_t MEM_BASE = 32'h8000_0000;

  // console register, matched on bits 31:3 only
  localparam addr_t UART_ADDR = 32'h1000_0000;

endpackage

`default_nettype wire

// ==== logic/stall_lfsr.sv ====
`timescale 1ns/1ns
`default_nettype none

module stall_lfsr #(
  parameter bit STALL_EN = 1'b1
) (
  input  wire  clk,
  input  wire  arst_n_i,
  output logic go_o
);

  localparam logic [19:0] SEED = 20'd101;

  logic [19:0] lfsr_q;

  // fibonacci, taps 20 and 17
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  // free-running either way, only the permit is forced
  assign go_o = STALL_EN ? lfsr_q[19] : 1'b1;

endmodule

`default_nettype wire

// ==== logic/sram_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_bank #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  wire                           clk,
  input  wire                           rd_en_i,
  input  wire                           wr_en_i,
  input  wire [$clog2(MEM_WORDS)-1:0]   idx_i,
  input  wire bus_slave_pkg::data_t     wdata_i,
  input  wire bus_slave_pkg::strb_t     strb_i,
  output bus_slave_pkg::data_t          rdata_o
);
  import bus_slave_pkg::*;

  localparam int unsigned LANES = $bits(strb_t);

  data_t mem_q [MEM_WORDS];

  // byte lanes follow the strobe
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int b = 0; b < LANES; b++) begin
        if (strb_i[b]) begin
          mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // registered read, data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
  parameter int unsigned CLKS_PER_BIT = 16
) (
  input  wire       clk,
  input  wire       arst_n_i,
  input  wire       load_i,
  input  wire [7:0] byte_i,
  output logic      busy_o,
  output logic      tx_o
);

  localparam int unsigned CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [3:0] STOP_BIT = 4'd9;

  logic [CNT_W-1:0] clk_cnt_q;
  // index of the bit on the line, 0 is the start bit
  logic [3:0]       bit_cnt_q;
  // remaining data bits with the stop bit on top
  logic [8:0]       shift_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_o    <= 1'b0;
      tx_o      <= 1'b1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      shift_q   <= '1;
    end else if (!busy_o) begin
      // start bit goes out right away
      if (load_i) begin
        busy_o    <= 1'b1;
        tx_o      <= 1'b0;
        clk_cnt_q <= '0;
        bit_cnt_q <= '0;
        shift_q   <= {1'b1, byte_i};
      end
    end else if (clk_cnt_q != CNT_LAST) begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end else begin
      clk_cnt_q <= '0;
      if (bit_cnt_q == STOP_BIT) begin
        // line already idles high from the stop bit
        busy_o <= 1'b0;
      end else begin
        tx_o      <= shift_q[0];
        shift_q   <= {1'b1, shift_q[8:1]};
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/bus_slave_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_slave_ctrl #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  wire                           clk,
  input  wire                           arst_n_i,
  input  wire                           go_i,
  // read channels
  input  wire                           arvalid_i,
  output logic                          arready_o,
  input  wire bus_slave_pkg::addr_t     araddr_i,
  input  wire bus_slave_pkg::axi_id_t   arid_i,
  output logic                          rvalid_o,
  input  wire                           rready_i,
  output bus_slave_pkg::data_t          rdata_o,
  output bus_slave_pkg::axi_id_t        rid_o,
  output bus_slave_pkg::axi_resp_t      rresp_o,
  // write channels
  input  wire                           awvalid_i,
  output logic                          awready_o,
  input  wire bus_slave_pkg::addr_t     awaddr_i,
  input  wire bus_slave_pkg::axi_id_t   awid_i,
  input  wire                           wvalid_i,
  output logic                          wready_o,
  input  wire bus_slave_pkg::data_t     wdata_i,
  input  wire bus_slave_pkg::strb_t     wstrb_i,
  output logic                          bvalid_o,
  input  wire                           bready_i,
  output bus_slave_pkg::axi_id_t        bid_o,
  output bus_slave_pkg::axi_resp_t      bresp_o,
  // sram side
  output logic                          mem_rd_en_o,
  output logic                          mem_wr_en_o,
  output logic [$clog2(MEM_WORDS)-1:0]  mem_idx_o,
  output bus_slave_pkg::data_t          mem_wdata_o,
  output bus_slave_pkg::strb_t          mem_strb_o,
  input  wire bus_slave_pkg::data_t     mem_rdata_i,
  // console side
  output logic                          uart_load_o,
  output logic [7:0]                    uart_byte_o,
  input  wire                           uart_busy_i
);
  import bus_slave_pkg::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);
  localparam addr_t MEM_BYTES = addr_t'(MEM_WORDS * 8);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_RD_RESP = 2'd1;
  localparam logic [1:0] ST_WR_RESP = 2'd2;

  localparam logic [1:0] SRC_MEM  = 2'd0;
  localparam logic [1:0] SRC_UART = 2'd1;
  localparam logic [1:0] SRC_ERR  = 2'd2;

  logic [1:0] state_q;
  logic [1:0] rd_src_q;
  logic       rd_busy_q;

  addr_t ar_off;
  addr_t aw_off;
  logic  ar_mem;
  logic  ar_uart;
  logic  aw_mem;
  logic  aw_uart;
  logic  rd_acc;
  logic  wr_acc;

  // address decode, offsets wrap below MEM_BASE so one compare covers both ends
  assign ar_off  = araddr_i - MEM_BASE;
  assign aw_off  = awaddr_i - MEM_BASE;
  assign ar_mem  = ar_off < MEM_BYTES;
  assign aw_mem  = aw_off < MEM_BYTES;
  assign ar_uart = araddr_i[31:3] == UART_ADDR[31:3];
  assign aw_uart = awaddr_i[31:3] == UART_ADDR[31:3];

  // read wins, console write waits for the transmitter
  assign rd_acc = go_i && (state_q == ST_IDLE) && arvalid_i;
  assign wr_acc = go_i && (state_q == ST_IDLE) && !arvalid_i && awvalid_i && wvalid_i &&
                  !(aw_uart && uart_busy_i);

  assign arready_o = rd_acc;
  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;
  assign rvalid_o  = (state_q == ST_RD_RESP);
  assign bvalid_o  = (state_q == ST_WR_RESP);

  assign mem_rd_en_o = rd_acc && ar_mem;
  assign mem_wr_en_o = wr_acc && aw_mem;
  assign mem_idx_o   = arvalid_i ? ar_off[IDX_W+2:3] : aw_off[IDX_W+2:3];
  assign mem_wdata_o = wdata_i;
  assign mem_strb_o  = wstrb_i;
  assign uart_load_o = wr_acc && aw_uart;
  assign uart_byte_o = wdata_i[7:0];

  always_comb begin
    case (rd_src_q)
      SRC_MEM:  rdata_o = mem_rdata_i;
      SRC_UART: rdata_o = data_t'(rd_busy_q);
      default:  rdata_o = '0;
    endcase
  end

  // stalls only hold back acceptance, a raised valid stays until its ready
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (rd_acc) begin
            state_q <= ST_RD_RESP;
          end else if (wr_acc) begin
            state_q <= ST_WR_RESP;
          end
        end
        ST_RD_RESP: begin
          if (rready_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_WR_RESP: begin
          if (bready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // response payload, captured at acceptance
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rid_o     <= arid_i;
      rresp_o   <= (ar_mem || ar_uart) ? RESP_OKAY : RESP_SLVERR;
      rd_src_q  <= ar_mem ? SRC_MEM : (ar_uart ? SRC_UART : SRC_ERR);
      rd_busy_q <= uart_busy_i;
    end
    if (wr_acc) begin
      bid_o   <= awid_i;
      bresp_o <= (aw_mem || aw_uart) ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

// ==== logic/mem_uart_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_uart_slave #(
  parameter int unsigned MEM_WORDS    = 256,
  parameter int unsigned CLKS_PER_BIT = 16,
  parameter bit          STALL_EN     = 1'b1
) (
  input  wire                           clk,
  input  wire                           arst_n_i,
  input  wire                           arvalid_i,
  output wire                           arready_o,
  input  wire bus_slave_pkg::addr_t     araddr_i,
  input  wire bus_slave_pkg::axi_id_t   arid_i,
  output wire                           rvalid_o,
  input  wire                           rready_i,
  output wire bus_slave_pkg::data_t     rdata_o,
  output wire bus_slave_pkg::axi_id_t   rid_o,
  output wire bus_slave_pkg::axi_resp_t rresp_o,
  input  wire                           awvalid_i,
  output wire                           awready_o,
  input  wire bus_slave_pkg::addr_t     awaddr_i,
  input  wire bus_slave_pkg::axi_id_t   awid_i,
  input  wire                           wvalid_i,
  output wire                           wready_o,
  input  wire bus_slave_pkg::data_t     wdata_i,
  input  wire bus_slave_pkg::strb_t     wstrb_i,
  output wire                           bvalid_o,
  input  wire                           bready_i,
  output wire bus_slave_pkg::axi_id_t   bid_o,
  output wire bus_slave_pkg::axi_resp_t bresp_o,
  output wire                           uart_tx_o
);
  import bus_slave_pkg::*;

  logic                         go;
  logic                         mem_rd_en;
  logic                         mem_wr_en;
  logic [$clog2(MEM_WORDS)-1:0] mem_idx;
  data_t                        mem_wdata;
  strb_t                        mem_strb;
  data_t                        mem_rdata;
  logic                         uart_load;
  logic [7:0]                   uart_byte;
  logic                         uart_busy;

  stall_lfsr #(
    .STALL_EN (STALL_EN)
  ) u_lfsr (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .go_o     (go)
  );

  bus_slave_ctrl #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ctrl (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .go_i        (go),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .araddr_i    (araddr_i),
    .arid_i      (arid_i),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .rdata_o     (rdata_o),
    .rid_o       (rid_o),
    .rresp_o     (rresp_o),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .awaddr_i    (awaddr_i),
    .awid_i      (awid_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .bid_o       (bid_o),
    .bresp_o     (bresp_o),
    .mem_rd_en_o (mem_rd_en),
    .mem_wr_en_o (mem_wr_en),
    .mem_idx_o   (mem_idx),
    .mem_wdata_o (mem_wdata),
    .mem_strb_o  (mem_strb),
    .mem_rdata_i (mem_rdata),
    .uart_load_o (uart_load),
    .uart_byte_o (uart_byte),
    .uart_busy_i (uart_busy)
  );

  sram_bank #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk     (clk),
    .rd_en_i (mem_rd_en),
    .wr_en_i (mem_wr_en),
    .idx_i   (mem_idx),
    .wdata_i (mem_wdata),
    .strb_i  (mem_strb),
    .rdata_o (mem_rdata)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (uart_load),
    .byte_i   (uart_byte),
    .busy_o   (uart_busy),
    .tx_o     (uart_tx_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_mem_uart_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_uart_slave;
  import bus_slave_pkg::*;

  localparam int unsigned MEM_WORDS    = 256;
  localparam int unsigned CLKS_PER_BIT = 4;
  localparam int unsigned BUS_TIMEOUT  = 200;
  localparam int unsigned UART_TIMEOUT = 40 * CLKS_PER_BIT * 10;
  localparam time         CLK_PERIOD   = 40;
  // next console write no earlier than one cycle after the frame ends
  localparam time         FRAME_GAP    = (10 * CLKS_PER_BIT + 1) * CLK_PERIOD;

  logic      clk;
  logic      arst_n;
  logic      arvalid;
  logic      arready;
  addr_t     araddr;
  axi_id_t   arid;
  logic      rvalid;
  logic      rready;
  data_t     rdata;
  axi_id_t   rid;
  axi_resp_t rresp;
  logic      awvalid;
  logic      awready;
  addr_t     awaddr;
  axi_id_t   awid;
  logic      wvalid;
  logic      wready;
  data_t     wdata;
  strb_t     wstrb;
  logic      bvalid;
  logic      bready;
  axi_id_t   bid;
  axi_resp_t bresp;
  logic      uart_tx;

  data_t ref_mem [MEM_WORDS];
  bit    written [MEM_WORDS];
  int    error_count;
  int    check_count;

  mem_uart_slave #(
    .MEM_WORDS    (MEM_WORDS),
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .STALL_EN     (1'b1)
  ) u_dut (
    .clk       (clk),
    .arst_n_i  (arst_n),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .arid_i    (arid),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rid_o     (rid),
    .rresp_o   (rresp),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .awid_i    (awid),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bid_o     (bid),
    .bresp_o   (bresp),
    .uart_tx_o (uart_tx)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic abort_run(input string what);
    error_count++;
    $display("%s", what);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // leaves the inputs 2 ns after a rising edge
  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // byte-strobe rule of the sram
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic do_write(input addr_t addr, input axi_id_t id, input data_t data,
                          input strb_t strb, output axi_resp_t resp, output axi_id_t resp_id,
                          output time t_acc);
    bit done;
    awvalid = 1'b1;
    awaddr  = addr;
    awid    = id;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    bready  = 1'b1;
    done    = 1'b0;
    for (int n = 0; n < BUS_TIMEOUT && !done; n++) begin
      @(negedge clk);
      done = awready && wready;
    end
    if (!done) abort_run("write request was never accepted");
    @(posedge clk);
    t_acc = $time;
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    done    = 1'b0;
    for (int n = 0; n < BUS_TIMEOUT && !done; n++) begin
      @(negedge clk);
      done = bvalid;
    end
    if (!done) abort_run("write response never arrived");
    resp    = bresp;
    resp_id = bid;
    @(posedge clk);
    #2;
    bready = 1'b0;
  endtask

  task automatic do_read(input addr_t addr, input axi_id_t id, output data_t data,
                         output axi_resp_t resp, output axi_id_t resp_id);
    bit done;
    arvalid = 1'b1;
    araddr  = addr;
    arid    = id;
    rready  = 1'b1;
    done    = 1'b0;
    for (int n = 0; n < BUS_TIMEOUT && !done; n++) begin
      @(negedge clk);
      done = arready;
    end
    if (!done) abort_run("read request was never accepted");
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    done    = 1'b0;
    for (int n = 0; n < BUS_TIMEOUT && !done; n++) begin
      @(negedge clk);
      done = rvalid;
    end
    if (!done) abort_run("read response never arrived");
    data    = rdata;
    resp    = rresp;
    resp_id = rid;
    @(posedge clk);
    #2;
    rready = 1'b0;
  endtask

  task automatic write_checked(input addr_t addr, input data_t data, input strb_t strb,
                               input axi_resp_t exp_resp, output time t_acc);
    axi_id_t   id;
    axi_id_t   got_id;
    axi_resp_t resp;
    id = axi_id_t'($urandom);
    do_write(addr, id, data, strb, resp, got_id, t_acc);
    check_resp("bresp", resp, exp_resp);
    check_id("bid", got_id, id);
  endtask

  task automatic read_checked(input addr_t addr, input data_t exp_data,
                              input axi_resp_t exp_resp);
    axi_id_t   id;
    axi_id_t   got_id;
    axi_resp_t resp;
    data_t     data;
    id = axi_id_t'($urandom);
    do_read(addr, id, data, resp, got_id);
    check_data("rdata", data, exp_data);
    check_resp("rresp", resp, exp_resp);
    check_id("rid", got_id, id);
  endtask

  // samples each bit near its middle on falling edges
  task automatic sample_uart(output logic [7:0] data);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < UART_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = (uart_tx == 1'b0);
    end
    if (!seen) abort_run("no start bit seen on the serial line");
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    if (uart_tx !== 1'b0) begin
      error_count++;
      $display("start bit at %0t ns is shorter than half a bit time", $time);
    end
    for (int b = 0; b < 8; b++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[b] = uart_tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    if (uart_tx !== 1'b1) begin
      error_count++;
      $display("stop bit missing on the serial line at %0t ns", $time);
    end
  endtask

  task automatic test_full_words();
    int unsigned idx;
    addr_t       addr;
    data_t       data;
    time         t_acc;
    for (int i = 0; i < 12; i++) begin
      idx  = $urandom % MEM_WORDS;
      addr = MEM_BASE + addr_t'(idx * 8);
      data = {$urandom, $urandom};
      write_checked(addr, data, '1, RESP_OKAY, t_acc);
      ref_mem[idx] = data;
      written[idx] = 1'b1;
      read_checked(addr, ref_mem[idx], RESP_OKAY);
    end
  endtask

  task automatic test_partial_writes();
    int unsigned idx;
    addr_t       addr;
    data_t       data;
    strb_t       strb;
    time         t_acc;
    for (int i = 0; i < 4; i++) begin
      idx  = $urandom % MEM_WORDS;
      addr = MEM_BASE + addr_t'(idx * 8);
      // known background first since untouched bytes are undefined
      data = {$urandom, $urandom};
      write_checked(addr, data, '1, RESP_OKAY, t_acc);
      ref_mem[idx] = data;
      written[idx] = 1'b1;
      for (int k = 0; k < 3; k++) begin
        data = {$urandom, $urandom};
        strb = strb_t'($urandom);
        write_checked(addr, data, strb, RESP_OKAY, t_acc);
        ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
        read_checked(addr, ref_mem[idx], RESP_OKAY);
      end
    end
  endtask

  task automatic test_error_addresses();
    addr_t       bad_addrs [5];
    int unsigned idx;
    data_t       data;
    time         t_acc;
    bad_addrs[0] = MEM_BASE - 32'd8;
    bad_addrs[1] = MEM_BASE + addr_t'(MEM_WORDS * 8);
    bad_addrs[2] = 32'h0000_0100;
    bad_addrs[3] = UART_ADDR + 32'd8;
    bad_addrs[4] = 32'hF000_0000 | ($urandom & 32'h0FFF_FFF8);
    // known words where a bad address lands if its upper bits are dropped
    for (int i = 0; i < 5; i++) begin
      idx  = (bad_addrs[i] >> 3) % MEM_WORDS;
      data = {$urandom, $urandom};
      write_checked(MEM_BASE + addr_t'(idx * 8), data, '1, RESP_OKAY, t_acc);
      ref_mem[idx] = data;
      written[idx] = 1'b1;
    end
    for (int i = 0; i < 5; i++) begin
      write_checked(bad_addrs[i], {$urandom, $urandom}, '1, RESP_SLVERR, t_acc);
      read_checked(bad_addrs[i], '0, RESP_SLVERR);
    end
    // nothing in the window may have moved
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (written[i]) begin
        read_checked(MEM_BASE + addr_t'(i * 8), ref_mem[i], RESP_OKAY);
      end
    end
  endtask

  task automatic test_console_frames();
    logic [7:0] chars [3];
    logic [7:0] got [3];
    time        t_acc [3];
    chars[0] = 8'h48;
    chars[1] = 8'h69;
    chars[2] = 8'h21;
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          sample_uart(got[i]);
        end
      end
      begin
        for (int i = 0; i < 3; i++) begin
          write_checked(UART_ADDR, data_t'(chars[i]), 8'h01, RESP_OKAY, t_acc[i]);
        end
      end
    join
    for (int i = 0; i < 3; i++) begin
      check_byte("uart byte", got[i], chars[i]);
    end
    for (int i = 1; i < 3; i++) begin
      if (t_acc[i] - t_acc[i-1] < FRAME_GAP) begin
        error_count++;
        $display("console write %0d accepted at %0t ns while the previous frame was running",
                 i, t_acc[i]);
      end
    end
    idle_cycles(CLKS_PER_BIT);
  endtask

  task automatic test_busy_status();
    logic [7:0] got;
    time        t_acc;
    fork
      sample_uart(got);
      begin
        write_checked(UART_ADDR, data_t'(8'hA5), 8'h01, RESP_OKAY, t_acc);
        read_checked(UART_ADDR, data_t'(1), RESP_OKAY);
      end
    join
    check_byte("uart byte", got, 8'hA5);
    // stop bit was sampled mid-bit so let the frame end
    idle_cycles(CLKS_PER_BIT);
    read_checked(UART_ADDR, '0, RESP_OKAY);
  endtask

  initial begin
    int unsigned seed_ret;
    seed_ret    = $urandom(68);
    error_count = 0;
    check_count = 0;
    arst_n  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    arid    = '0;
    rready  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    awid    = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = '0;
      written[i] = 1'b0;
    end
    idle_cycles(2);
    arst_n = 1'b1;
    idle_cycles(2);
    test_full_words();
    test_partial_writes();
    test_error_addresses();
    test_console_frames();
    test_busy_status();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/bus_slave_pkg.sv
logic/stall_lfsr.sv
logic/sram_bank.sv
logic/uart_tx.sv
logic/bus_slave_ctrl.sv
logic/mem_uart_slave.sv
testbench/tb_mem_uart_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_mem_uart_slave -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "no pass line in sim.log"
  exit 1
fi
exit 0
